// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= tb_ber_monitor
RTL_TOP    ?= ber_monitor_top
FILELIST   ?= sim.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --timescale 1ns/1ps
LINT_FLAGS ?= --lint-only -Wall --timescale 1ns/1ps

SRCS     := $(shell grep -v '^+' $(FILELIST))
RTL_SRCS := $(filter design/%,$(SRCS))
SIM_BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "TEST OK" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== design/ber_counters.sv ====
`timescale 1ns/1ps

module ber_counters (
  input  logic                clk,
  input  logic                w_reset,
  input  logic                i_clear,
  input  logic                i_snapshot,
  input  ber_pkg::log_sel_t   i_cnt_sel,
  input  logic                i_sym_valid,
  input  logic                i_err_i,
  input  logic                i_err_q,
  output ber_pkg::gpio_word_t o_cnt_word
);
  import ber_pkg::*;

  // counter slots, in readback order
  localparam int IDX_ERR_I = 0;
  localparam int IDX_BIT_I = 1;
  localparam int IDX_ERR_Q = 2;
  localparam int IDX_BIT_Q = 3;
  localparam int N_CNT     = 4;

  // live counters and their frozen copies
  count_t     r_cnt  [N_CNT];
  count_t     r_snap [N_CNT];

  // per slot increment for this symbol
  logic [N_CNT-1:0] w_inc;

  // readback select split into slot and half
  logic [1:0] w_slot;
  logic       w_upper;

  // bit counters see every symbol
  assign w_inc[IDX_ERR_I] = i_err_i;
  assign w_inc[IDX_BIT_I] = 1'b1;
  assign w_inc[IDX_ERR_Q] = i_err_q;
  assign w_inc[IDX_BIT_Q] = 1'b1;

  // ==================================================
  // counting and snapshot
  // ==================================================
  always_ff @(posedge clk) begin
    if (w_reset || i_clear) begin
      for (int k = 0; k < N_CNT; k++) begin
        r_cnt[k]  <= '0;
        r_snap[k] <= '0;
      end
    end else begin
      for (int k = 0; k < N_CNT; k++) begin
        if (i_sym_valid) begin
          r_cnt[k] <= r_cnt[k] + COUNT_W'(w_inc[k]);
        end
        // copy holds until next snapshot or clear
        if (i_snapshot) begin
          r_snap[k] <= r_cnt[k];
        end
      end
    end
  end

  // ==================================================
  // half-word readback
  // ==================================================
  // sel 2:1 picks the counter, sel 0 the half
  assign w_slot  = i_cnt_sel[2:1];
  assign w_upper = i_cnt_sel[0];

  assign o_cnt_word = w_upper ? r_snap[w_slot][COUNT_W-1:GPIO_W]
                              : r_snap[w_slot][GPIO_W-1:0];

endmodule

// ==== design/ber_monitor_top.sv ====
`timescale 1ns/1ps

module ber_monitor_top #(
  parameter int LOG_DEPTH = 32768
) (
  input  logic                clk,
  input  logic                w_reset,
  // host command and readback
  input  ber_pkg::gpio_word_t i_gpio_cmd,
  output ber_pkg::gpio_word_t o_gpio_data,
  // equalizer output stream
  input  logic                i_sym_valid,
  input  ber_pkg::sample_t    i_sample_i,
  input  ber_pkg::sample_t    i_sample_q,
  // per symbol slicer errors
  input  logic                i_err_i,
  input  logic                i_err_q
);
  import ber_pkg::*;

  // counter control and readback
  logic       w_cnt_snapshot;
  logic       w_cnt_clear;
  log_sel_t   w_cnt_sel;
  gpio_word_t w_cnt_word;

  // log RAM readback
  gpio_word_t w_ram_word;

  // logger controls from the register file
  log_ctrl_if #(
    .LOG_DEPTH (LOG_DEPTH)
  ) u_log_ctrl ();

  // ==================================================
  // register file
  // ==================================================
  cmd_regfile #(
    .LOG_DEPTH (LOG_DEPTH)
  ) u_regfile (
    .clk            (clk),
    .w_reset        (w_reset),
    .i_gpio_cmd     (i_gpio_cmd),
    .o_gpio_data    (o_gpio_data),
    .o_log          (u_log_ctrl.regfile),
    .o_cnt_snapshot (w_cnt_snapshot),
    .o_cnt_clear    (w_cnt_clear),
    .o_cnt_sel      (w_cnt_sel),
    .i_cnt_word     (w_cnt_word),
    .i_ram_word     (w_ram_word)
  );

  // ==================================================
  // error and bit counters
  // ==================================================
  ber_counters u_counters (
    .clk         (clk),
    .w_reset     (w_reset),
    .i_clear     (w_cnt_clear),
    .i_snapshot  (w_cnt_snapshot),
    .i_cnt_sel   (w_cnt_sel),
    .i_sym_valid (i_sym_valid),
    .i_err_i     (i_err_i),
    .i_err_q     (i_err_q),
    .o_cnt_word  (w_cnt_word)
  );

  // ==================================================
  // sample logger
  // ==================================================
  sample_logger #(
    .LOG_DEPTH (LOG_DEPTH)
  ) u_logger (
    .clk         (clk),
    .w_reset     (w_reset),
    .i_log       (u_log_ctrl.logger),
    .i_sym_valid (i_sym_valid),
    .i_sample_i  (i_sample_i),
    .i_sample_q  (i_sample_q),
    .o_ram_word  (w_ram_word)
  );

endmodule

// ==== design/ber_pkg.sv ====
package ber_pkg;

  // ==================================================
  // word widths and their vector types
  // ==================================================

  // host command and readback word
  localparam int GPIO_W = 32;
  typedef logic [GPIO_W-1:0] gpio_word_t;

  // one error or bit counter
  localparam int COUNT_W = 64;
  typedef logic [COUNT_W-1:0] count_t;

  // equalizer output sample, two's complement
  localparam int SAMPLE_W = 12;
  typedef logic signed [SAMPLE_W-1:0] sample_t;

  // log source select and readback half-word select
  typedef logic [2:0] log_sel_t;

  // ==================================================
  // command word encoding
  // ==================================================

  // strobe marks a valid command for one cycle
  localparam int CMD_STROBE_BIT = 23;

  // opcodes in bits 31:24
  localparam logic [7:0] OP_SOFT_RESET = 8'h01;
  localparam logic [7:0] OP_LOG_ARM    = 8'h03;
  localparam logic [7:0] OP_RAM_READ   = 8'h04;
  localparam logic [7:0] OP_SNAPSHOT   = 8'h05;
  localparam logic [7:0] OP_CNT_READ   = 8'h06;

  // log buffer fill states
  typedef enum logic [1:0] {
    LOG_IDLE = 2'd0,
    LOG_FILL = 2'd1,
    LOG_FULL = 2'd2
  } logger_state_t;

endpackage

// ==== design/cmd_regfile.sv ====
`timescale 1ns/1ps

module cmd_regfile #(
  parameter int LOG_DEPTH = 32768
) (
  input  logic                clk,
  input  logic                w_reset,
  input  ber_pkg::gpio_word_t i_gpio_cmd,
  output ber_pkg::gpio_word_t o_gpio_data,
  log_ctrl_if.regfile         o_log,
  output logic                o_cnt_snapshot,
  output logic                o_cnt_clear,
  output ber_pkg::log_sel_t   o_cnt_sel,
  input  ber_pkg::gpio_word_t i_cnt_word,
  input  ber_pkg::gpio_word_t i_ram_word
);
  import ber_pkg::*;

  localparam int ADDR_W = $clog2(LOG_DEPTH);

  // command field positions
  localparam int OP_LSB      = 24;
  localparam int ARM_EN_BIT  = 3;
  localparam int RD_EN_BIT   = 16;
  localparam int CNT_EN_BIT  = 3;
  localparam int ACTION_BIT  = 0;

  // decoded fields of the incoming word
  logic              w_strobe;
  logic [7:0]        w_opcode;

  // control registers
  logic              r_write_en;
  log_sel_t          r_log_sel;
  logic              r_read_en;
  logic [ADDR_W-1:0] r_read_addr;
  logic              r_cnt_rd_en;
  log_sel_t          r_cnt_sel;
  logic              r_snapshot;
  logic              r_clear;

  assign w_strobe = i_gpio_cmd[CMD_STROBE_BIT];
  assign w_opcode = i_gpio_cmd[OP_LSB +: 8];

  // ==================================================
  // command decode
  // ==================================================
  always_ff @(posedge clk) begin
    if (w_reset) begin
      r_write_en  <= 1'b0;
      r_log_sel   <= '0;
      r_read_en   <= 1'b0;
      r_read_addr <= '0;
      r_cnt_rd_en <= 1'b0;
      r_cnt_sel   <= '0;
      r_snapshot  <= 1'b0;
      r_clear     <= 1'b0;
    end else begin
      // pulses last a single cycle
      r_snapshot <= 1'b0;
      r_clear    <= 1'b0;
      if (w_strobe) begin
        // every accepted word drops the enables first
        r_write_en  <= 1'b0;
        r_read_en   <= 1'b0;
        r_cnt_rd_en <= 1'b0;
        case (w_opcode)
          OP_SOFT_RESET: begin
            r_clear <= i_gpio_cmd[ACTION_BIT];
          end
          OP_LOG_ARM: begin
            r_log_sel  <= i_gpio_cmd[2:0];
            r_write_en <= i_gpio_cmd[ARM_EN_BIT];
          end
          OP_RAM_READ: begin
            r_read_en   <= i_gpio_cmd[RD_EN_BIT];
            r_read_addr <= i_gpio_cmd[ADDR_W-1:0];
          end
          OP_SNAPSHOT: begin
            r_snapshot <= i_gpio_cmd[ACTION_BIT];
          end
          OP_CNT_READ: begin
            r_cnt_sel   <= i_gpio_cmd[2:0];
            r_cnt_rd_en <= i_gpio_cmd[CNT_EN_BIT];
          end
          default: begin
            // unknown opcode, enables already dropped
          end
        endcase
      end
    end
  end

  // ==================================================
  // outputs
  // ==================================================

  // logger controls
  assign o_log.write_en  = r_write_en;
  assign o_log.log_sel   = r_log_sel;
  assign o_log.read_en   = r_read_en;
  assign o_log.read_addr = r_read_addr;
  assign o_log.clear     = r_clear;

  // counter controls
  assign o_cnt_snapshot = r_snapshot;
  assign o_cnt_clear    = r_clear;
  assign o_cnt_sel      = r_cnt_sel;

  // readback select, RAM wins over counters
  always_comb begin
    if (r_read_en) begin
      o_gpio_data = i_ram_word;
    end else if (r_cnt_rd_en) begin
      o_gpio_data = i_cnt_word;
    end else begin
      o_gpio_data = '0;
    end
  end

endmodule

// ==== design/log_ctrl_if.sv ====
`timescale 1ns/1ps

interface log_ctrl_if #(
  parameter int LOG_DEPTH = 32768
);
  import ber_pkg::*;

  // log RAM address width
  localparam int ADDR_W = $clog2(LOG_DEPTH);

  // arm the logger
  logic              write_en;
  // which stream goes into the RAM
  log_sel_t          log_sel;
  // host read of the RAM
  logic              read_en;
  logic [ADDR_W-1:0] read_addr;
  // one cycle pulse, restarts the logger
  logic              clear;

  // register file side drives every control
  modport regfile (
    output write_en, log_sel, read_en, read_addr, clear
  );

  // logger only listens
  modport logger (
    input write_en, log_sel, read_en, read_addr, clear
  );

endinterface

// ==== design/sample_logger.sv ====
`timescale 1ns/1ps

module sample_logger #(
  parameter int LOG_DEPTH = 32768
) (
  input  logic                clk,
  input  logic                w_reset,
  log_ctrl_if.logger          i_log,
  input  logic                i_sym_valid,
  input  ber_pkg::sample_t    i_sample_i,
  input  ber_pkg::sample_t    i_sample_q,
  output ber_pkg::gpio_word_t o_ram_word
);
  import ber_pkg::*;

  localparam int ADDR_W = $clog2(LOG_DEPTH);
  localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(LOG_DEPTH - 1);
  // sign bits needed to fill a word from one sample
  localparam int EXT_W  = GPIO_W - SAMPLE_W;
  // zero bits above the packed I/Q pair
  localparam int PAD_W  = GPIO_W - 2 * SAMPLE_W;

  logger_state_t     r_state;
  logic [ADDR_W-1:0] r_wr_addr;
  gpio_word_t        w_log_word;
  logic              w_wr;

  // log storage and its read register
  gpio_word_t        mem [LOG_DEPTH];
  gpio_word_t        r_rd_word;

  // ==================================================
  // source select
  // ==================================================
  always_comb begin
    case (i_log.log_sel)
      3'd0:    w_log_word = {{EXT_W{i_sample_i[SAMPLE_W-1]}}, i_sample_i};
      3'd1:    w_log_word = {{EXT_W{i_sample_q[SAMPLE_W-1]}}, i_sample_q};
      // I high, Q low
      3'd2:    w_log_word = {{PAD_W{1'b0}}, i_sample_i, i_sample_q};
      default: w_log_word = '0;
    endcase
  end

  // one word per symbol while filling
  assign w_wr = (r_state == LOG_FILL) && i_log.write_en && i_sym_valid;

  // ==================================================
  // fill state machine
  // ==================================================
  always_ff @(posedge clk) begin
    if (w_reset || i_log.clear) begin
      r_state   <= LOG_IDLE;
      r_wr_addr <= '0;
    end else begin
      case (r_state)
        LOG_IDLE: begin
          // each fill starts at address 0
          if (i_log.write_en) begin
            r_state   <= LOG_FILL;
            r_wr_addr <= '0;
          end
        end
        LOG_FILL: begin
          if (!i_log.write_en) begin
            r_state <= LOG_IDLE;
          end else if (i_sym_valid) begin
            if (r_wr_addr == LAST_ADDR) begin
              r_state <= LOG_FULL;
            end else begin
              r_wr_addr <= r_wr_addr + 1'b1;
            end
          end
        end
        // full buffer waits for a clear
        LOG_FULL: begin
          r_state <= LOG_FULL;
        end
        default: begin
          r_state <= LOG_IDLE;
        end
      endcase
    end
  end

  // ==================================================
  // RAM ports
  // ==================================================
  always_ff @(posedge clk) begin
    if (w_wr) begin
      mem[r_wr_addr] <= w_log_word;
    end
    // registered read, address changes land one edge later
    if (i_log.read_en) begin
      r_rd_word <= mem[i_log.read_addr];
    end
  end

  assign o_ram_word = r_rd_word;

endmodule

// ==== sim.f ====
design/ber_pkg.sv
design/log_ctrl_if.sv
design/cmd_regfile.sv
design/ber_counters.sv
design/sample_logger.sv
design/ber_monitor_top.sv
verification/ber_checker.sv
verification/tb_ber_monitor.sv

// ==== verification/ber_checker.sv ====
`timescale 1ns/1ps

module ber_checker #(
  parameter int LOG_DEPTH = 16
) (
  input  logic                clk,
  input  logic                w_reset,
  // everything the DUT sees
  input  ber_pkg::gpio_word_t i_gpio_cmd,
  input  logic                i_sym_valid,
  input  ber_pkg::sample_t    i_sample_i,
  input  ber_pkg::sample_t    i_sample_q,
  input  logic                i_err_i,
  input  logic                i_err_q,
  // DUT readback
  input  ber_pkg::gpio_word_t i_gpio_data,
  // fixed expectation from the stimulus table
  input  logic                i_exp_en,
  input  ber_pkg::gpio_word_t i_exp_word,
  output int                  o_err_count,
  output int                  o_check_count
);
  import ber_pkg::*;

  localparam int AW = $clog2(LOG_DEPTH);
  localparam logic [AW-1:0] END_ADDR = AW'(LOG_DEPTH - 1);

  // control registers as the host sees them
  logic          m_wr_en;
  logic          m_rd_en;
  logic          m_cnt_en;
  logic          m_snap;
  logic          m_clr;
  log_sel_t      m_src;
  log_sel_t      m_half;
  logic [AW-1:0] m_rd_addr;

  // live counts, the two bit counters always agree
  count_t        m_err_i;
  count_t        m_err_q;
  count_t        m_bits;
  // frozen copies
  count_t        s_err_i;
  count_t        s_err_q;
  count_t        s_bits;

  // log buffer model
  logger_state_t m_state;
  logic [AW-1:0] m_ptr;
  gpio_word_t    m_mem [LOG_DEPTH];
  // addresses written since reset
  logic          m_known [LOG_DEPTH];
  gpio_word_t    m_rd_word;
  logic          m_rd_known;

  int            err_cnt = 0;
  int            chk_cnt = 0;

  assign o_err_count   = err_cnt;
  assign o_check_count = chk_cnt;

  // word stored for one symbol, by source
  function automatic gpio_word_t log_word(log_sel_t src, sample_t si, sample_t sq);
    gpio_word_t w;
    case (src)
      3'd0:    w = gpio_word_t'(int'(si));
      3'd1:    w = gpio_word_t'(int'(sq));
      3'd2:    w = {8'h00, si, sq};
      default: w = '0;
    endcase
    return w;
  endfunction

  // snapshot half-word, even select is the low half
  function automatic gpio_word_t half_word(log_sel_t sel);
    count_t c;
    case (sel[2:1])
      2'd0:    c = s_err_i;
      2'd2:    c = s_err_q;
      default: c = s_bits;
    endcase
    return sel[0] ? c[63:32] : c[31:0];
  endfunction

  // what o_gpio_data should carry right now
  function automatic gpio_word_t readback();
    if (m_rd_en) begin
      return m_rd_word;
    end
    if (m_cnt_en) begin
      return half_word(m_half);
    end
    return '0;
  endfunction

  task automatic compare(input string src, input gpio_word_t want);
    chk_cnt++;
    if (i_gpio_data !== want) begin
      err_cnt++;
      $display("** Error o_gpio_data (%s): expected 0x%08h, got 0x%08h at %0t",
               src, want, i_gpio_data, $time);
    end
  endtask

  // ==================================================
  // reference model, stepped on every rising edge
  // ==================================================
  always @(posedge clk) begin
    if (w_reset) begin
      m_wr_en    <= 1'b0;
      m_rd_en    <= 1'b0;
      m_cnt_en   <= 1'b0;
      m_snap     <= 1'b0;
      m_clr      <= 1'b0;
      m_src      <= '0;
      m_half     <= '0;
      m_rd_addr  <= '0;
      m_err_i    <= '0;
      m_err_q    <= '0;
      m_bits     <= '0;
      s_err_i    <= '0;
      s_err_q    <= '0;
      s_bits     <= '0;
      m_state    <= LOG_IDLE;
      m_ptr      <= '0;
      m_rd_known <= 1'b0;
      for (int a = 0; a < LOG_DEPTH; a++) begin
        m_known[a] <= 1'b0;
      end
    end else begin
      // pulses last one cycle
      m_snap <= 1'b0;
      m_clr  <= 1'b0;
      if (i_gpio_cmd[CMD_STROBE_BIT]) begin
        m_wr_en  <= 1'b0;
        m_rd_en  <= 1'b0;
        m_cnt_en <= 1'b0;
        case (i_gpio_cmd[31:24])
          OP_SOFT_RESET: m_clr <= i_gpio_cmd[0];
          OP_SNAPSHOT:   m_snap <= i_gpio_cmd[0];
          OP_LOG_ARM: begin
            m_src   <= i_gpio_cmd[2:0];
            m_wr_en <= i_gpio_cmd[3];
          end
          OP_RAM_READ: begin
            m_rd_en   <= i_gpio_cmd[16];
            m_rd_addr <= i_gpio_cmd[AW-1:0];
          end
          OP_CNT_READ: begin
            m_half   <= i_gpio_cmd[2:0];
            m_cnt_en <= i_gpio_cmd[3];
          end
          default: ;
        endcase
      end
      // clear pulse beats counting and logging
      if (m_clr) begin
        m_err_i <= '0;
        m_err_q <= '0;
        m_bits  <= '0;
        s_err_i <= '0;
        s_err_q <= '0;
        s_bits  <= '0;
        m_state <= LOG_IDLE;
        m_ptr   <= '0;
      end else begin
        if (i_sym_valid) begin
          m_bits  <= m_bits + 64'd1;
          m_err_i <= m_err_i + count_t'(i_err_i);
          m_err_q <= m_err_q + count_t'(i_err_q);
        end
        if (m_snap) begin
          s_err_i <= m_err_i;
          s_err_q <= m_err_q;
          s_bits  <= m_bits;
        end
        case (m_state)
          LOG_IDLE: begin
            if (m_wr_en) begin
              m_state <= LOG_FILL;
              m_ptr   <= '0;
            end
          end
          LOG_FILL: begin
            if (!m_wr_en) begin
              m_state <= LOG_IDLE;
            end else if (i_sym_valid) begin
              m_mem[m_ptr]   <= log_word(m_src, i_sample_i, i_sample_q);
              m_known[m_ptr] <= 1'b1;
              if (m_ptr == END_ADDR) begin
                m_state <= LOG_FULL;
              end else begin
                m_ptr <= m_ptr + AW'(1);
              end
            end
          end
          // full stays full until a clear
          default: ;
        endcase
      end
      // registered read sees the RAM before this edge's write
      if (m_rd_en) begin
        m_rd_word  <= m_mem[m_rd_addr];
        m_rd_known <= m_known[m_rd_addr];
      end
    end
  end

  // ==================================================
  // compare mid-cycle where the readback is stable
  // ==================================================
  always @(negedge clk) begin
    if (!w_reset) begin
      // read register not loaded from a written address yet
      if (!(m_rd_en && !m_rd_known)) begin
        compare("model", readback());
      end
      if (i_exp_en) begin
        compare("table", i_exp_word);
      end
    end
  end

endmodule

// ==== verification/tb_ber_monitor.sv ====
`timescale 1ns/1ps

module tb_ber_monitor;
  import ber_pkg::*;

  localparam int LOG_DEPTH    = 16;
  localparam int RESET_CYCLES = 5;
  localparam int TAIL_CYCLES  = 4;
  // all-error burst length gives a known count
  localparam int BURST_LEN    = 37;

  // symbol patterns
  localparam int SYM_CLEAN   = 0;
  localparam int SYM_RAND    = 1;
  localparam int SYM_ALL_ERR = 2;
  localparam int SYM_GAPPY   = 3;

  // one table row with command, symbols after it and expected readback
  typedef struct packed {
    gpio_word_t cmd;
    int         nsym;
    int         mode;
    logic       chk;
    gpio_word_t exp;
  } step_t;

  logic       clk = 1'b0;
  logic       w_reset;
  gpio_word_t gpio_cmd;
  gpio_word_t gpio_data;
  logic       sym_valid;
  sample_t    sample_i;
  sample_t    sample_q;
  logic       err_i;
  logic       err_q;
  logic       exp_en;
  gpio_word_t exp_word;
  int         err_count;
  int         check_count;

  step_t      steps[$];
  int         cycle_cnt = 0;
  int         cycle_limit = 0;

  // 4 ns clock
  always #2 clk = ~clk;

  ber_monitor_top #(
    .LOG_DEPTH (LOG_DEPTH)
  ) u_dut (
    .clk         (clk),
    .w_reset     (w_reset),
    .i_gpio_cmd  (gpio_cmd),
    .o_gpio_data (gpio_data),
    .i_sym_valid (sym_valid),
    .i_sample_i  (sample_i),
    .i_sample_q  (sample_q),
    .i_err_i     (err_i),
    .i_err_q     (err_q)
  );

  ber_checker #(
    .LOG_DEPTH (LOG_DEPTH)
  ) u_chk (
    .clk           (clk),
    .w_reset       (w_reset),
    .i_gpio_cmd    (gpio_cmd),
    .i_sym_valid   (sym_valid),
    .i_sample_i    (sample_i),
    .i_sample_q    (sample_q),
    .i_err_i       (err_i),
    .i_err_q       (err_q),
    .i_gpio_data   (gpio_data),
    .i_exp_en      (exp_en),
    .i_exp_word    (exp_word),
    .o_err_count   (err_count),
    .o_check_count (check_count)
  );

  // strobed command word
  function automatic gpio_word_t make_cmd(logic [7:0] op, logic [22:0] arg);
    return {op, 1'b1, arg};
  endfunction

  task automatic add_step(input gpio_word_t cmd, input int nsym, input int mode,
                          input logic chk, input gpio_word_t exp);
    step_t s;
    s.cmd  = cmd;
    s.nsym = nsym;
    s.mode = mode;
    s.chk  = chk;
    s.exp  = exp;
    steps.push_back(s);
  endtask

  // snapshot then all eight halves with lo expected in the low halves
  task automatic add_count_reads(input logic chk, input gpio_word_t lo);
    add_step(make_cmd(OP_SNAPSHOT, 23'd1), 0, SYM_CLEAN, 1'b0, '0);
    for (int s = 0; s < 8; s++) begin
      add_step(make_cmd(OP_CNT_READ, 23'(8 + s)), 0, SYM_CLEAN, chk,
               (s % 2 == 0) ? lo : '0);
    end
  endtask

  task automatic add_ram_read(input int addr, input logic chk, input gpio_word_t exp);
    add_step(make_cmd(OP_RAM_READ, 23'h10000 | 23'(addr)), 0, SYM_CLEAN, chk, exp);
  endtask

  // ==================================================
  // stimulus table
  // ==================================================
  task automatic build_table();
    // idle readback and zero counts after reset
    add_step('0, 0, SYM_CLEAN, 1'b1, '0);
    add_count_reads(1'b1, '0);
    // random traffic then every half-word
    add_step('0, 300, SYM_RAND, 1'b0, '0);
    add_step('0, 200, SYM_GAPPY, 1'b0, '0);
    add_count_reads(1'b0, '0);
    // known burst after a soft reset
    add_step(make_cmd(OP_SOFT_RESET, 23'd1), BURST_LEN, SYM_ALL_ERR, 1'b1, '0);
    add_count_reads(1'b1, gpio_word_t'(BURST_LEN));
    add_step(make_cmd(OP_CNT_READ, 23'd10), 0, SYM_CLEAN, 1'b1, gpio_word_t'(BURST_LEN));
    // readback stays without the strobe
    add_step({OP_SOFT_RESET, 24'h000001}, 0, SYM_CLEAN, 1'b1, gpio_word_t'(BURST_LEN));
    // unknown opcode only drops the enables
    add_step(make_cmd(8'h7f, 23'd10), 0, SYM_CLEAN, 1'b1, '0);
    add_step(make_cmd(OP_CNT_READ, 23'd10), 0, SYM_CLEAN, 1'b1, gpio_word_t'(BURST_LEN));
    // soft reset without bit 0 clears nothing
    add_step(make_cmd(OP_SOFT_RESET, 23'd0), 0, SYM_CLEAN, 1'b1, '0);
    add_step(make_cmd(OP_CNT_READ, 23'd8), 0, SYM_CLEAN, 1'b1, gpio_word_t'(BURST_LEN));
    // real clear zeroes the snapshot too
    add_step(make_cmd(OP_SOFT_RESET, 23'd1), 0, SYM_CLEAN, 1'b1, '0);
    add_step(make_cmd(OP_CNT_READ, 23'd8), 0, SYM_CLEAN, 1'b1, '0);
    add_step(make_cmd(OP_CNT_READ, 23'd10), 0, SYM_CLEAN, 1'b1, '0);
    // logging from each source
    add_step(make_cmd(OP_LOG_ARM, 23'h8), 10, SYM_RAND, 1'b0, '0);
    add_ram_read(0, 1'b0, '0);
    add_ram_read(4, 1'b0, '0);
    add_ram_read(9, 1'b0, '0);
    // RAM read with the enable low hides the logged word
    add_step(make_cmd(OP_RAM_READ, 23'd3), 0, SYM_CLEAN, 1'b1, '0);
    add_step(make_cmd(OP_LOG_ARM, 23'h9), 10, SYM_GAPPY, 1'b0, '0);
    add_ram_read(0, 1'b0, '0);
    add_ram_read(5, 1'b0, '0);
    add_step(make_cmd(OP_LOG_ARM, 23'ha), 12, SYM_RAND, 1'b0, '0);
    add_ram_read(0, 1'b0, '0);
    add_ram_read(11, 1'b0, '0);
    // unused source writes zero
    add_step(make_cmd(OP_LOG_ARM, 23'hd), 4, SYM_RAND, 1'b0, '0);
    add_ram_read(2, 1'b1, '0);
    // overfill then arm again while full
    add_step(make_cmd(OP_LOG_ARM, 23'ha), 24, SYM_RAND, 1'b0, '0);
    add_ram_read(15, 1'b0, '0);
    add_ram_read(14, 1'b0, '0);
    add_step(make_cmd(OP_LOG_ARM, 23'h8), 6, SYM_RAND, 1'b0, '0);
    add_ram_read(15, 1'b0, '0);
    add_ram_read(0, 1'b0, '0);
    // clear restarts the fill from address 0
    add_step(make_cmd(OP_SOFT_RESET, 23'd1), 0, SYM_CLEAN, 1'b0, '0);
    add_step(make_cmd(OP_LOG_ARM, 23'h8), 5, SYM_RAND, 1'b0, '0);
    add_ram_read(4, 1'b0, '0);
    add_ram_read(15, 1'b0, '0);
    add_count_reads(1'b0, '0);
  endtask

  // random sample pair plus valid and error flags
  task automatic drive_symbol(input int mode);
    logic [31:0] r;
    r = $urandom();
    sample_i  <= r[11:0];
    sample_q  <= r[27:16];
    sym_valid <= (mode == SYM_GAPPY) ? (r[30] | r[31]) : 1'b1;
    case (mode)
      SYM_CLEAN: begin
        err_i <= 1'b0;
        err_q <= 1'b0;
      end
      SYM_ALL_ERR: begin
        err_i <= 1'b1;
        err_q <= 1'b1;
      end
      default: begin
        err_i <= r[12] & r[13];
        err_q <= r[28] & r[29];
      end
    endcase
  endtask

  // cycle budget guard
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("timeout: stimulus still running after %0d clock cycles", cycle_cnt);
      $display("TEST FAILED");
      $finish;
    end
  end

  // ==================================================
  // reset, apply loop, summary
  // ==================================================
  initial begin
    step_t step;
    void'($urandom(32'he4a));
    w_reset   = 1'b1;
    gpio_cmd  = '0;
    sym_valid = 1'b0;
    sample_i  = '0;
    sample_q  = '0;
    err_i     = 1'b0;
    err_q     = 1'b0;
    exp_en    = 1'b0;
    exp_word  = '0;
    build_table();
    // command cycle and three settle cycles per row
    cycle_limit = RESET_CYCLES + TAIL_CYCLES + 100;
    foreach (steps[e]) begin
      cycle_limit += 4 + steps[e].nsym;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    w_reset <= 1'b0;
    for (int e = 0; e < steps.size(); e++) begin
      step = steps[e];
      @(posedge clk);
      gpio_cmd  <= step.cmd;
      sym_valid <= 1'b0;
      err_i     <= 1'b0;
      err_q     <= 1'b0;
      exp_en    <= 1'b0;
      @(posedge clk);
      gpio_cmd <= '0;
      @(posedge clk);
      // RAM readback lands two cycles after the command
      @(posedge clk);
      exp_en   <= step.chk;
      exp_word <= step.exp;
      for (int n = 0; n < step.nsym; n++) begin
        @(posedge clk);
        exp_en <= 1'b0;
        drive_symbol(step.mode);
      end
    end
    @(posedge clk);
    sym_valid <= 1'b0;
    err_i     <= 1'b0;
    err_q     <= 1'b0;
    exp_en    <= 1'b0;
    repeat (TAIL_CYCLES) @(posedge clk);
    $display("summary: %0d checks, %0d errors", check_count, err_count);
    if (err_count == 0 && check_count > 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
